/* design/rv_pkg.sv */
package rv_pkg;

    // Datapath widths
    localparam int xlen       = 32;           // RV32
    localparam int reg_addr_w = 5;            // x0..x31

    // Instruction class, set by decode
    localparam logic [2:0] op_load_store = 3'b000;  // Address is rs1+imm
    localparam logic [2:0] op_branch     = 3'b001;  // Conditional, compares rs1 with rs2
    localparam logic [2:0] op_reg_imm    = 3'b010;  // R-type or I-type arithmetic
    localparam logic [2:0] op_jal        = 3'b011;
    localparam logic [2:0] op_lui        = 3'b100;
    localparam logic [2:0] op_auipc      = 3'b101;
    localparam logic [2:0] op_jalr       = 3'b111;
    // 3'b110 has no class and gives an all-zero result

    // ALU control, laid out as {funct7[5], funct3}
    localparam logic [3:0] alu_add  = 4'b0000;
    localparam logic [3:0] alu_sll  = 4'b0001;
    localparam logic [3:0] alu_slt  = 4'b0010;
    localparam logic [3:0] alu_sltu = 4'b0011;
    localparam logic [3:0] alu_xor  = 4'b0100;
    localparam logic [3:0] alu_srl  = 4'b0101;
    localparam logic [3:0] alu_or   = 4'b0110;
    localparam logic [3:0] alu_and  = 4'b0111;
    localparam logic [3:0] alu_sub  = 4'b1000;
    localparam logic [3:0] alu_sra  = 4'b1101;

    // Branch codes, same as the B-type funct3
    localparam logic [2:0] br_beq  = 3'b000;
    localparam logic [2:0] br_bne  = 3'b001;
    localparam logic [2:0] br_blt  = 3'b100;
    localparam logic [2:0] br_bge  = 3'b101;
    localparam logic [2:0] br_bltu = 3'b110;
    localparam logic [2:0] br_bgeu = 3'b111;
    // 3'b010 and 3'b011 are not branches

    // ID/EX bundle, 148 bits
    typedef struct packed {
        logic [2:0]            op_class;     // Instruction class
        logic [3:0]            alu_ctrl;     // Used by reg_imm only
        logic                  alu_src;      // 1 selects imm, 0 selects rs2
        logic [2:0]            branch_op;    // Branch funct3
        logic [xlen-1:0]       rs1_value;
        logic [xlen-1:0]       rs2_value;
        logic [xlen-1:0]       imm;          // Already sign extended / shifted by decode
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
    } id_ex_t;

    // EX/MEM bundle, 106 bits
    typedef struct packed {
        logic [xlen-1:0]       result;       // ALU output or link value
        logic [xlen-1:0]       store_data;   // rs2 for stores
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  taken;        // Redirect fetch
        logic [xlen-1:0]       target;       // Redirect address
    } ex_mem_t;

endpackage

/* design/alu.sv */
module alu (
    input  logic [3:0]              alu_ctrl,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] y,
    output logic                    zero,
    output logic                    lt,
    output logic                    ltu
);
    import rv_pkg::*;

    logic [xlen:0]   diff;      // One extra bit catches the borrow
    logic            ovf;       // Signed overflow of a - b
    logic [4:0]      shamt;

    // Single subtractor serves sub, the compares and the branch flags
    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[4:0];      // RV32 only looks at the low five bits

    // Overflow when the signs differ and the result sign is not a's
    assign ovf  = (a[xlen-1] ^ b[xlen-1]) & (a[xlen-1] ^ diff[xlen-1]);

    assign zero = (diff[xlen-1:0] == '0);
    assign lt   = diff[xlen-1] ^ ovf;   // Sign corrected for overflow
    assign ltu  = diff[xlen];           // Borrow out means a < b unsigned

    always_comb
    begin
        case (alu_ctrl)
            alu_add:
            begin
                y = a + b;
            end
            alu_sub:
            begin
                y = diff[xlen-1:0];
            end
            alu_sll:
            begin
                y = a << shamt;
            end
            alu_slt:
            begin
                y = {{(xlen-1){1'b0}}, lt};
            end
            alu_sltu:
            begin
                y = {{(xlen-1){1'b0}}, ltu};
            end
            alu_xor:
            begin
                y = a ^ b;
            end
            alu_srl:
            begin
                y = a >> shamt;         // Zero fill
            end
            alu_sra:
            begin
                y = $unsigned($signed(a) >>> shamt);   // Sign fill
            end
            alu_or:
            begin
                y = a | b;
            end
            alu_and:
            begin
                y = a & b;
            end
            default:
            begin
                y = '0;                 // Unused codes
            end
        endcase
    end

endmodule

/* design/branch_unit.sv */
module branch_unit (
    input  logic [2:0]              op_class,
    input  logic [2:0]              branch_op,
    input  logic                    zero,
    input  logic                    lt,
    input  logic                    ltu,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] rs1_value,
    input  logic [rv_pkg::xlen-1:0] imm,
    output logic                    taken,
    output logic [rv_pkg::xlen-1:0] target
);
    import rv_pkg::*;

    logic            cond;      // Branch condition from the ALU flags
    logic [xlen-1:0] base;
    logic [xlen-1:0] sum;

    always_comb
    begin
        case (branch_op)
            br_beq:  cond = zero;
            br_bne:  cond = ~zero;
            br_blt:  cond = lt;
            br_bge:  cond = ~lt;
            br_bltu: cond = ltu;
            br_bgeu: cond = ~ltu;
            default: cond = 1'b0;   // Not a branch code, never taken
        endcase
    end

    // Jumps always redirect
    assign taken = (op_class == op_branch) ? cond :
                   ((op_class == op_jal) || (op_class == op_jalr));

    // Own adder, the ALU is busy comparing for branches
    assign base = (op_class == op_jalr) ? rs1_value : pc;
    assign sum  = base + imm;

    always_comb
    begin
        case (op_class)
            op_branch, op_jal: target = sum;
            op_jalr:           target = {sum[xlen-1:1], 1'b0};  // LSB dropped per spec
            default:           target = '0;
        endcase
    end

endmodule

/* design/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t d,
    output logic     out_valid,
    output payload_t q
);

    // Valid follows the strobe every cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid strobe, otherwise it holds
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            q <= '0;
        end
        else if (in_valid)
        begin
            q <= d;
        end
    end

endmodule

/* design/execute.sv */
module execute (
    input  logic              id_valid,
    input  rv_pkg::id_ex_t    id,
    output logic              ex_valid,
    output rv_pkg::ex_mem_t   ex
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;          // ALU operand a
    logic [xlen-1:0] op_b;          // ALU operand b
    logic [3:0]      ctrl;          // ALU control after class override
    logic [xlen-1:0] alu_y;
    logic            zero;
    logic            lt;
    logic            ltu;
    logic            taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;          // Return address for jumps
    logic [xlen-1:0] result;

    // Operand a
    always_comb
    begin
        case (id.op_class)
            op_jal, op_auipc:
            begin
                op_a = id.pc;
            end
            op_lui:
            begin
                op_a = '0;          // 0 + imm gives the upper immediate
            end
            default:
            begin
                op_a = id.rs1_value;    // load/store, branch, reg_imm, jalr
            end
        endcase
    end

    // Operand b
    always_comb
    begin
        if (id.op_class == op_branch)
        begin
            op_b = id.rs2_value;    // Compare rs1 against rs2
        end
        else if ((id.op_class == op_reg_imm) && !id.alu_src)
        begin
            op_b = id.rs2_value;    // R-type
        end
        else
        begin
            op_b = id.imm;
        end
    end

    // Only reg_imm uses the decoded control
    always_comb
    begin
        case (id.op_class)
            op_reg_imm: ctrl = id.alu_ctrl;
            op_branch:  ctrl = alu_sub;     // Flags need a - b
            default:    ctrl = alu_add;     // Address, lui, auipc
        endcase
    end

    alu u_alu (
        .alu_ctrl (ctrl),
        .a        (op_a),
        .b        (op_b),
        .y        (alu_y),
        .zero     (zero),
        .lt       (lt),
        .ltu      (ltu)
    );

    branch_unit u_branch (
        .op_class  (id.op_class),
        .branch_op (id.branch_op),
        .zero      (zero),
        .lt        (lt),
        .ltu       (ltu),
        .pc        (id.pc),
        .rs1_value (id.rs1_value),
        .imm       (id.imm),
        .taken     (taken),
        .target    (target)
    );

    assign link = id.pc + xlen'(4);

    // Result by class
    always_comb
    begin
        case (id.op_class)
            op_load_store, op_reg_imm, op_lui, op_auipc:
            begin
                result = alu_y;
            end
            op_jal, op_jalr:
            begin
                result = link;
            end
            default:
            begin
                result = '0;        // Branches write nothing
            end
        endcase
    end

    // EX/MEM bundle, memory and writeback controls ride along untouched
    always_comb
    begin
        ex.result     = result;
        ex.store_data = id.rs2_value;
        ex.rd         = id.rd;
        ex.reg_write  = id.reg_write;
        ex.mem_read   = id.mem_read;
        ex.mem_write  = id.mem_write;
        ex.mem_to_reg = id.mem_to_reg;
        ex.taken      = taken;
        ex.target     = target;
    end

    assign ex_valid = id_valid;     // No stalls in this stage

endmodule

/* design/exec_stage.sv */
module exec_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  logic [2:0]                    op_class,
    input  logic [3:0]                    alu_ctrl,
    input  logic                          alu_src,
    input  logic [2:0]                    branch_op,
    input  logic [rv_pkg::xlen-1:0]       rs1_value,
    input  logic [rv_pkg::xlen-1:0]       rs2_value,
    input  logic [rv_pkg::xlen-1:0]       imm,
    input  logic [rv_pkg::xlen-1:0]       pc,
    input  logic [rv_pkg::reg_addr_w-1:0] rd,
    input  logic                          reg_write,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic                          mem_to_reg,
    output logic                          out_valid,
    output logic [rv_pkg::xlen-1:0]       result,
    output logic [rv_pkg::xlen-1:0]       store_data,
    output logic [rv_pkg::reg_addr_w-1:0] out_rd,
    output logic                          out_reg_write,
    output logic                          out_mem_read,
    output logic                          out_mem_write,
    output logic                          out_mem_to_reg,
    output logic                          out_taken,
    output logic [rv_pkg::xlen-1:0]       out_target
);
    import rv_pkg::*;

    id_ex_t  id_d;          // Decode fields gathered into one bundle
    id_ex_t  id_q;
    logic    id_valid;
    ex_mem_t ex_d;
    logic    ex_valid;
    ex_mem_t ex_q;

    assign id_d.op_class   = op_class;
    assign id_d.alu_ctrl   = alu_ctrl;
    assign id_d.alu_src    = alu_src;
    assign id_d.branch_op  = branch_op;
    assign id_d.rs1_value  = rs1_value;
    assign id_d.rs2_value  = rs2_value;
    assign id_d.imm        = imm;
    assign id_d.pc         = pc;
    assign id_d.rd         = rd;
    assign id_d.reg_write  = reg_write;
    assign id_d.mem_read   = mem_read;
    assign id_d.mem_write  = mem_write;
    assign id_d.mem_to_reg = mem_to_reg;

    // ID/EX register
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .d         (id_d),
        .out_valid (id_valid),
        .q         (id_q)
    );

    execute u_execute (
        .id_valid (id_valid),
        .id       (id_q),
        .ex_valid (ex_valid),
        .ex       (ex_d)
    );

    // EX/MEM register
    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (ex_valid),
        .d         (ex_d),
        .out_valid (out_valid),
        .q         (ex_q)
    );

    // Bundle back out to loose ports
    assign result         = ex_q.result;
    assign store_data     = ex_q.store_data;
    assign out_rd         = ex_q.rd;
    assign out_reg_write  = ex_q.reg_write;
    assign out_mem_read   = ex_q.mem_read;
    assign out_mem_write  = ex_q.mem_write;
    assign out_mem_to_reg = ex_q.mem_to_reg;
    assign out_taken      = ex_q.taken;
    assign out_target     = ex_q.target;

endmodule

/* tb/exec_sva.sv */
module exec_sva (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid,
    input logic out_mem_write,
    input logic out_reg_write,
    input logic out_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    // Every strobe shows up two edges later
    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##2 out_valid)
        else $error("out_valid missing two cycles after in_valid");

    // And nothing comes out that was not strobed in
    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 2))
        else $error("out_valid without in_valid two cycles earlier");

    // Quiet in reset and the first cycle out of it
    a_reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !(out_valid || out_mem_write || out_reg_write))
        else $error("outputs active during or just after reset");

    // Taken holds with the payload between results and only moves with out_valid
    a_taken_valid: assert property (@(posedge clk) disable iff (rst)
        $changed(out_taken) |-> out_valid)
        else $error("out_taken changed without out_valid");

endmodule

bind exec_stage exec_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .out_valid     (out_valid),
    .out_mem_write (out_mem_write),
    .out_reg_write (out_reg_write),
    .out_taken     (out_taken)
);

/* tb/tb_exec.sv */
module tb_exec;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int n_vec   = 30;        // Lines in the vector file
    localparam int n_burst = 15;        // Leading vectors sent back to back
    localparam int vec_w   = 224;       // 56 hex digits per line
    localparam int period  = 40;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic [2:0]            op_class;
    logic [3:0]            alu_ctrl;
    logic                  alu_src;
    logic [2:0]            branch_op;
    logic [xlen-1:0]       rs1_value;
    logic [xlen-1:0]       rs2_value;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rd;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  out_valid;
    logic [xlen-1:0]       result;
    logic [xlen-1:0]       store_data;
    logic [reg_addr_w-1:0] out_rd;
    logic                  out_reg_write;
    logic                  out_mem_read;
    logic                  out_mem_write;
    logic                  out_mem_to_reg;
    logic                  out_taken;
    logic [xlen-1:0]       out_target;

    logic [vec_w-1:0] vectors [n_vec];
    int               exp_q[$];         // Vector index per instruction in flight
    int               edge_q[$];        // Edge count when each strobe was driven
    int               edge_count = 0;
    int               n_done     = 0;
    logic [31:0]      lcg_state;

    exec_stage dut0 (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .op_class       (op_class),
        .alu_ctrl       (alu_ctrl),
        .alu_src        (alu_src),
        .branch_op      (branch_op),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .imm            (imm),
        .pc             (pc),
        .rd             (rd),
        .reg_write      (reg_write),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_to_reg     (mem_to_reg),
        .out_valid      (out_valid),
        .result         (result),
        .store_data     (store_data),
        .out_rd         (out_rd),
        .out_reg_write  (out_reg_write),
        .out_mem_read   (out_mem_read),
        .out_mem_write  (out_mem_write),
        .out_mem_to_reg (out_mem_to_reg),
        .out_taken      (out_taken),
        .out_target     (out_target)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period / 2) clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        edge_count <= edge_count + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;   // Numerical Recipes constants
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] got);
        if (got !== exp)
        begin
            stop_on_error($sformatf("ERR %s exp=%h got=%h", name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp)
        begin
            stop_on_error($sformatf("ERR %s exp=%h got=%h", name, exp, got));
        end
    endtask

    task automatic check_rd(input string name, input logic [reg_addr_w-1:0] exp,
                            input logic [reg_addr_w-1:0] got);
        if (got !== exp)
        begin
            stop_on_error($sformatf("ERR %s exp=%h got=%h", name, exp, got));
        end
    endtask

    // Everything cleared, nothing valid
    task automatic check_idle_outputs();
        check_bit("out_valid", 1'b0, out_valid);
        check_word("result", '0, result);
        check_word("store_data", '0, store_data);
        check_rd("out_rd", '0, out_rd);
        check_bit("out_reg_write", 1'b0, out_reg_write);
        check_bit("out_mem_read", 1'b0, out_mem_read);
        check_bit("out_mem_write", 1'b0, out_mem_write);
        check_bit("out_mem_to_reg", 1'b0, out_mem_to_reg);
        check_bit("out_taken", 1'b0, out_taken);
        check_word("out_target", '0, out_target);
    endtask

    task automatic drive_vector(input int i);
        logic [vec_w-1:0] v;
        v          = vectors[i];
        in_valid   = 1'b1;
        op_class   = v[222:220];
        alu_ctrl   = v[219:216];
        alu_src    = v[212];
        branch_op  = v[210:208];
        rs1_value  = v[207:176];
        rs2_value  = v[175:144];
        imm        = v[143:112];
        pc         = v[111:80];
        rd         = v[76:72];
        {reg_write, mem_read, mem_write, mem_to_reg} = v[71:68];
        exp_q.push_back(i);
        edge_q.push_back(edge_count);
    endtask

    // Oldest instruction in flight against the outputs
    task automatic check_result();
        int               i;
        int               e;
        logic [vec_w-1:0] v;
        if (exp_q.size() == 0)
        begin
            stop_on_error("out_valid was high with no instruction in flight");
        end
        i = exp_q.pop_front();
        e = edge_q.pop_front();
        v = vectors[i];
        if (edge_count != e + 2)
        begin
            stop_on_error($sformatf("vector %0d came out %0d edges after its strobe, not 2",
                                    i, edge_count - e));
        end
        check_word("result", v[63:32], result);
        check_word("store_data", v[175:144], store_data);   // Always rs2
        check_rd("out_rd", v[76:72], out_rd);
        check_bit("out_reg_write", v[71], out_reg_write);
        check_bit("out_mem_read", v[70], out_mem_read);
        check_bit("out_mem_write", v[69], out_mem_write);
        check_bit("out_mem_to_reg", v[68], out_mem_to_reg);
        check_bit("out_taken", v[64], out_taken);
        check_word("out_target", v[31:0], out_target);
        n_done++;
    endtask

    // Outputs settle after the rising edge, so look on the falling one
    always @(negedge clk)
    begin
        if (!rst && out_valid)
        begin
            check_result();
        end
    end

    initial
    begin
        int gap;
        rst = 1'b0;
        in_valid = 1'b0;
        op_class = '0;
        alu_ctrl = '0;
        alu_src = 1'b0;
        branch_op = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        pc = '0;
        rd = '0;
        {reg_write, mem_read, mem_write, mem_to_reg} = 4'b0000;
        lcg_state = 32'hcd19567c;
        $readmemh("tb/exec_vectors.txt", vectors);
        for (int i = 0; i < n_vec; i++)
        begin
            if ($isunknown(vectors[i]))
            begin
                stop_on_error($sformatf("vector %0d is missing or malformed in the file", i));
            end
        end
        #1 rst = 1'b1;          // Clean rising edge clears both registers
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        for (int i = 0; i < n_vec; i++)
        begin
            if (i >= n_burst)
            begin
                lcg_state = lcg_next(lcg_state);
                gap = (lcg_state >> 16) % 3;      // 0 to 2 idle cycles
                repeat (gap)
                begin
                    in_valid = 1'b0;
                    @(negedge clk);
                end
            end
            drive_vector(i);
            @(negedge clk);
        end
        in_valid = 1'b0;
        wait (n_done == n_vec);
        repeat (2) @(negedge clk);  // Room for a stray out_valid to show
        $display("=== PASS ===");
        $finish;
    end

    // Reset, worst case gaps and drain fit well inside this
    initial
    begin
        #((n_vec * 3 + 40) * period);
        stop_on_error($sformatf("run hung with %0d results outstanding", exp_q.size()));
    end

endmodule

/* tb/exec_vectors.txt */
// op alu src br _ rs1 _ rs2 _ imm _ pc _ rd(2) ctl taken _ result _ target
// ctl digit is {reg_write, mem_read, mem_write, mem_to_reg}, one hex digit per small field
2000_00000005_00000007_00000000_00001000_0180_0000000c_00000000
2800_00000003_00000005_00000000_00001004_0280_fffffffe_00000000
2100_00000001_0000001f_00000000_00001008_0380_80000000_00000000
2200_ffffffff_00000001_00000000_0000100c_0480_00000001_00000000
2300_ffffffff_00000001_00000000_00001010_0580_00000000_00000000
2410_ff00ff00_00000000_0f0f0f0f_00001014_0680_f00ff00f_00000000
2500_80000001_00000020_00000000_00001018_0780_80000001_00000000
2d10_f0000000_00000000_00000004_0000101c_0880_ff000000_00000000
2d00_80000000_0000001f_00000000_00001020_0980_ffffffff_00000000
2600_12340000_00005678_00000000_00001024_0a80_12345678_00000000
2710_12345678_00000000_0000ff00_00001028_0b80_00005600_00000000
0000_00002000_deadbeef_fffffffc_0000102c_10d0_00001ffc_00000000
0000_00003000_cafef00d_00000010_00001030_0020_00003010_00000000
1000_00000007_00000007_00000040_00000100_0001_00000000_00000140
1000_00000007_00000008_fffffff0_00000200_0000_00000000_000001f0
1001_00000001_00000002_00000008_00000300_0001_00000000_00000308
1001_00000005_00000005_0000000c_00000400_0000_00000000_0000040c
1004_ffffffff_00000001_00000020_00000500_0001_00000000_00000520
1004_00000001_ffffffff_00000010_00000600_0000_00000000_00000610
1005_00000001_ffffffff_fffffffc_00000700_0001_00000000_000006fc
1005_80000000_7fffffff_00000004_00000800_0000_00000000_00000804
1006_00000001_ffffffff_00000100_00000900_0001_00000000_00000a00
1006_ffffffff_00000001_00000008_00000a00_0000_00000000_00000a08
1007_ffffffff_00000001_00000010_00000b00_0001_00000000_00000b10
1007_00000000_00000001_00000004_00000c00_0000_00000000_00000c04
1002_00000003_00000003_00000008_00000d00_0000_00000000_00000d08
3000_00000000_00000000_00000800_00001000_0181_00001004_00001800
7000_00002001_00000000_00000004_00001100_0181_00001104_00002004
4000_ffffffff_00000000_12345000_00001200_0580_12345000_00000000
5000_deadbeef_00000000_00001000_00400000_0680_00401000_00000000

/* vlog.f */
design/rv_pkg.sv
design/alu.sv
design/branch_unit.sv
design/pipe_reg.sv
design/execute.sv
design/exec_stage.sv
tb/exec_sva.sv
tb/tb_exec.sv
